// ==== pcSequencer.f ====
+incdir+include
source/pcSequencerPkg.sv
source/seqInterfaces.sv
source/branchDecode.sv
source/operandFetch.sv
source/branchResolve.sv
source/pcSequencer.sv
tests/pcSequencer_assert.sv
tests/pcSequencer_tb.sv

// ==== Makefile ====
# Verilator build and run for the PC sequencer testbench

VERILATOR ?= verilator
TOP       ?= pcSequencer_tb
FILELIST  ?= pcSequencer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -qx "Simulation PASSED" $(LOG) || (echo "Run failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/pcSequencer_tb.sv ====
`timescale 1ns/100ps
`include "pcSequencer_config.svh"

module pcSequencer_tb;
	import pcSequencerPkg::*;

	localparam int resetCycles = 16;
	localparam int cycleLimit = `SEQ_TEST_COUNT + resetCycles + 20;

	logic clk = 1'b0;
	logic rst;
	logic instrValid, aluValid, aluCarry;
	wordT instr, aluData;
	regIdxT aluDest;
	logic nextPcValid, branchTaken;
	addrT nextPc;

	//////////////////////////////////////////////////
	// Model state
	//////////////////////////////////////////////////

	wordT modelRegs [`SEQ_REG_COUNT] = '{default: '0};
	logic modelCarry = 1'b0;
	addrT modelPc = `SEQ_RESET_PC;
	// Branches in flight, slot 0 decoded, slot 1 operands read
	logic stageValid [2] = '{1'b0, 1'b0};
	wordT stageInstr [2] = '{32'd0, 32'd0};
	wordT readData = '0;
	logic readCarry = 1'b0;
	// Return address waiting for its register write
	logic linkPending = 1'b0;
	wordT linkValue = '0;
	logic expValid, expTaken;

	logic [31:0] lfsrState = 32'd2092;
	int errorCount = 0;
	int issuedCount = 0;
	int seenCount = 0;
	int cycleCount = 0;

	pcSequencer u_dut (.*);

	bind pcSequencer pcSequencer_assert u_checks (
		.clk(clk), .rst(rst), .instrValid(instrValid),
		.nextPcValid(nextPcValid), .nextPc(nextPc), .branchTaken(branchTaken)
	);

	always #20 clk = ~clk;

	// Hard stop for a stalled pipeline
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Cycle limit hit, %0d branches never resolved", issuedCount - seenCount);
			$display("Simulation FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	// Mostly r0 to r3 and the link register
	function automatic regIdxT pickReg();
		regIdxT idx;
		case (2'(takeBits(2)))
			2'd0: idx = 5'(`SEQ_LINK_REG);
			2'd3: idx = 5'(takeBits(5));
			default: idx = 5'(takeBits(2));
		endcase
		return idx;
	endfunction

	// Branch rules, returns taken flag over next address
	function automatic logic [32:0] resolveBranch(wordT word, wordT opnd, logic cy, addrT pc);
		logic taken;
		addrT dest;
		taken = 1'b0;
		dest = {8'd0, word[23:0]};
		case (word[31:29])
			// br rs, always taken
			3'b001: begin
				taken = 1'b1;
				dest = opnd;
			end
			// b, bl, bcy, bcny
			3'b010: begin
				case (word[28:26])
					3'd0, 3'd1: taken = 1'b1;
					3'd2: taken = cy;
					3'd3: taken = ~cy;
					default: taken = 1'b0;
				endcase
			end
			// bltz, bz, bnz with the short label
			3'b100: begin
				dest = {13'd0, word[18:0]};
				case (word[28:26])
					3'd0: taken = opnd[31];
					3'd1: taken = (opnd == 32'd0);
					3'd2: taken = (opnd != 32'd0);
					default: taken = 1'b0;
				endcase
			end
			default: taken = 1'b0;
		endcase
		if (!taken) begin
			dest = pc + 32'd1;
		end
		return {taken, dest};
	endfunction

	// Mirror of one clock edge, then compare
	task automatic stepModel();
		logic [32:0] result;
		logic writeLink;
		wordT writeValue;
		writeLink = linkPending;
		writeValue = linkValue;
		linkPending = 1'b0;
		expValid = stageValid[1];
		expTaken = 1'b0;
		// Resolve against the latest counter
		if (stageValid[1]) begin
			result = resolveBranch(stageInstr[1], readData, readCarry, modelPc);
			expTaken = result[32];
			// bl, written back one edge later
			if (stageInstr[1][31:26] == 6'b010001) begin
				linkPending = 1'b1;
				linkValue = modelPc + 32'd1;
			end
			modelPc = result[31:0];
		end
		// Read sees registers before this edge
		stageValid[1] = stageValid[0];
		stageInstr[1] = stageInstr[0];
		readData = modelRegs[stageInstr[0][23:19]];
		readCarry = modelCarry;
		if (aluValid) begin
			modelRegs[aluDest] = aluData;
			modelCarry = aluCarry;
		end
		// Link beats a same-edge ALU write
		if (writeLink) begin
			modelRegs[`SEQ_LINK_REG] = writeValue;
		end
		stageValid[0] = instrValid;
		stageInstr[0] = instr;
		assert (nextPcValid === expValid) else begin
			errorCount++;
			$display("[FAIL] nextPcValid expected %h got %h", expValid, nextPcValid);
		end
		assert (branchTaken === expTaken) else begin
			errorCount++;
			$display("[FAIL] branchTaken expected %h got %h", expTaken, branchTaken);
		end
		assert (nextPc === modelPc) else begin
			errorCount++;
			$display("[FAIL] nextPc expected %h got %h", modelPc, nextPc);
		end
		if (nextPcValid) begin
			seenCount++;
		end
	endtask

	// New inputs for the next edge, strobes off when idle
	task automatic driveInputs(input logic active);
		logic [2:0] kind;
		instrValid = active && (takeBits(2) != 32'd0);
		case (3'(takeBits(3)))
			3'd0, 3'd1: kind = 3'b010;
			3'd2, 3'd3: kind = 3'b100;
			3'd4, 3'd5: kind = 3'b001;
			// Sometimes not one-hot
			default: kind = 3'(takeBits(3));
		endcase
		instr[31:29] = kind;
		instr[28:26] = 3'(takeBits(3));
		instr[25:24] = 2'(takeBits(2));
		instr[23:19] = pickReg();
		instr[18:0] = 19'(takeBits(19));
		if (instrValid) begin
			issuedCount++;
		end
		aluValid = active && (takeBits(1) != 32'd0);
		aluDest = pickReg();
		aluCarry = 1'(takeBits(1));
		// Zero, small, negative or any value
		case (2'(takeBits(2)))
			2'd0: aluData = '0;
			2'd1: aluData = 32'(takeBits(8));
			2'd2: aluData = {1'b1, 31'(takeBits(31))};
			default: aluData = takeBits(32);
		endcase
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		aluValid = 1'b0;
		aluDest = '0;
		aluData = '0;
		aluCarry = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int n = 0; n < `SEQ_TEST_COUNT; n++) begin
			@(posedge clk);
			#2;
			stepModel();
			driveInputs(1'b1);
		end
		// Idle until every strobe has its result
		while (seenCount < issuedCount) begin
			@(posedge clk);
			#2;
			stepModel();
			driveInputs(1'b0);
		end
		$display("Errors %0d, branches issued %0d, resolved %0d",
			errorCount, issuedCount, seenCount);
		if (errorCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== tests/pcSequencer_assert.sv ====
`timescale 1ns/100ps

module pcSequencer_assert (
	input logic                 clk,
	input logic                 rst,
	input logic                 instrValid,
	input logic                 nextPcValid,
	input pcSequencerPkg::addrT nextPc,
	input logic                 branchTaken
);
	import pcSequencerPkg::*;

	//////////////////////////////////////////////////
	// Strobe timing
	//////////////////////////////////////////////////

	// Decode, fetch and resolve, one cycle each
	latencyCheck: assert property (
		@(posedge clk) disable iff (rst)
		nextPcValid == $past(instrValid, 3)
	) else $error("nextPcValid does not follow instrValid by three cycles");

	// Taken flag only with a result
	takenNeedsValid: assert property (
		@(posedge clk) disable iff (rst)
		branchTaken |-> nextPcValid
	) else $error("branchTaken high without nextPcValid");

	//////////////////////////////////////////////////
	// Sequential step
	//////////////////////////////////////////////////

	// Not taken means counter plus one
	stepAddsOne: assert property (
		@(posedge clk) disable iff (rst)
		(nextPcValid && !branchTaken) |-> (nextPc == $past(nextPc) + 32'd1)
	) else $error("Untaken branch did not step the counter by one");

endmodule

// ==== source/pcSequencer.sv ====
`timescale 1ns/100ps

module pcSequencer (
	input  logic                   clk,
	input  logic                   rst,
	// Branch instruction strobe
	input  logic                   instrValid,
	input  pcSequencerPkg::wordT   instr,
	// ALU result strobe
	input  logic                   aluValid,
	input  pcSequencerPkg::regIdxT aluDest,
	input  pcSequencerPkg::wordT   aluData,
	input  logic                   aluCarry,
	// Resolved address, three cycles after instrValid
	output logic                   nextPcValid,
	output pcSequencerPkg::addrT   nextPc,
	output logic                   branchTaken
);
	import pcSequencerPkg::*;

	// Link write path back from resolve
	logic linkValid;
	wordT linkData;

	decodeIf decBus ();
	fetchIf fetBus ();

	//////////////////////////////////////////////////
	// Three-stage pipeline
	//////////////////////////////////////////////////

	branchDecode u_branchDecode (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.dec        (decBus.source)
	);

	// Register file and carry live here
	operandFetch u_operandFetch (
		.clk       (clk),
		.rst       (rst),
		.dec       (decBus.sink),
		.fet       (fetBus.source),
		.aluValid  (aluValid),
		.aluDest   (aluDest),
		.aluData   (aluData),
		.aluCarry  (aluCarry),
		.linkValid (linkValid),
		.linkData  (linkData)
	);

	branchResolve u_branchResolve (
		.clk         (clk),
		.rst         (rst),
		.fet         (fetBus.sink),
		.nextPcValid (nextPcValid),
		.nextPc      (nextPc),
		.branchTaken (branchTaken),
		.linkValid   (linkValid),
		.linkData    (linkData)
	);

endmodule

// ==== source/branchResolve.sv ====
`timescale 1ns/100ps
`include "pcSequencer_config.svh"

module branchResolve (
	input  logic                 clk,
	input  logic                 rst,
	fetchIf.sink                 fet,
	output logic                 nextPcValid,
	output pcSequencerPkg::addrT nextPc,
	output logic                 branchTaken,
	output logic                 linkValid,
	output pcSequencerPkg::wordT linkData
);
	import pcSequencerPkg::*;

	// Program counter, updated once per resolved branch
	addrT pcReg;
	addrT pcPlusOne;
	// Label widened to an address
	addrT labelAddr;
	// Address if the branch is taken
	addrT target;
	logic takeBranch;
	logic isLink;

	assign pcPlusOne = pcReg + addrT'(1);
	assign labelAddr = addrT'(fet.label);

	//////////////////////////////////////////////////
	// Next-address rules
	//////////////////////////////////////////////////

	always_comb begin
		takeBranch = 1'b0;
		target     = labelAddr;
		case (fet.bType)
			// br rs, always taken
			brReg: begin
				takeBranch = 1'b1;
				target     = fet.regData;
			end
			brLabel: begin
				case (fet.func)
					fnB, fnBl: takeBranch = 1'b1;
					fnBcy:     takeBranch = fet.carry;
					fnBcny:    takeBranch = ~fet.carry;
					default:   takeBranch = 1'b0;
				endcase
			end
			// Test on rs, label is the 19-bit form
			brTest: begin
				case (fet.func)
					fnBltz:  takeBranch = fet.regData[31];
					fnBz:    takeBranch = (fet.regData == '0);
					fnBnz:   takeBranch = (fet.regData != '0);
					default: takeBranch = 1'b0;
				endcase
			end
			// brNone, plain step
			default: takeBranch = 1'b0;
		endcase
	end

	// bl is the only linking branch
	assign isLink = (fet.bType == brLabel) && (fet.func == fnBl);

	//////////////////////////////////////////////////
	// Counter and result strobes
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			pcReg       <= addrT'(`SEQ_RESET_PC);
			nextPcValid <= 1'b0;
			branchTaken <= 1'b0;
			linkValid   <= 1'b0;
		end else begin
			nextPcValid <= fet.valid;
			branchTaken <= fet.valid & takeBranch;
			linkValid   <= fet.valid & isLink;
			// Counter holds between branches
			if (fet.valid) begin
				pcReg <= takeBranch ? target : pcPlusOne;
			end
		end
	end

	// Return address, old counter plus one
	always_ff @(posedge clk) begin
		if (fet.valid) begin
			linkData <= wordT'(pcPlusOne);
		end
	end

	// New counter is visible with nextPcValid
	assign nextPc = pcReg;

endmodule

// ==== source/operandFetch.sv ====
`timescale 1ns/100ps
`include "pcSequencer_config.svh"

module operandFetch (
	input  logic                   clk,
	input  logic                   rst,
	decodeIf.sink                  dec,
	fetchIf.source                 fet,
	input  logic                   aluValid,
	input  pcSequencerPkg::regIdxT aluDest,
	input  pcSequencerPkg::wordT   aluData,
	input  logic                   aluCarry,
	input  logic                   linkValid,
	input  pcSequencerPkg::wordT   linkData
);
	import pcSequencerPkg::*;

	localparam regIdxT linkIdx = regIdxT'(`SEQ_LINK_REG);

	// General registers, no hard-wired zero
	wordT regFile [`SEQ_REG_COUNT];
	logic carryFlag;

	// Combinational read of rs
	wordT readData;

	//////////////////////////////////////////////////
	// Register file and carry writes
	//////////////////////////////////////////////////

	// Writes land at the edge, reads in the same cycle see old data
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `SEQ_REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
			carryFlag <= 1'b0;
		end else begin
			if (aluValid) begin
				regFile[aluDest] <= aluData;
				// Every ALU strobe refreshes carry
				carryFlag <= aluCarry;
			end
			// Link write comes last so it beats an ALU write to the same register
			if (linkValid) begin
				regFile[linkIdx] <= linkData;
			end
		end
	end

	//////////////////////////////////////////////////
	// Operand read and stage register
	//////////////////////////////////////////////////

	// No bypass from writes in flight
	assign readData = regFile[dec.rs];

	always_ff @(posedge clk) begin
		if (rst) begin
			fet.valid <= 1'b0;
		end else begin
			fet.valid <= dec.valid;
		end
	end

	// Decoded fields pass through with the operand
	always_ff @(posedge clk) begin
		if (dec.valid) begin
			fet.bType   <= dec.bType;
			fet.func    <= dec.func;
			fet.label   <= dec.label;
			fet.regData <= readData;
			// Carry sampled as it stands before this edge
			fet.carry   <= carryFlag;
		end
	end

endmodule

// ==== source/branchDecode.sv ====
`timescale 1ns/100ps

module branchDecode (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 instrValid,
	input  pcSequencerPkg::wordT instr,
	decodeIf.source              dec
);
	import pcSequencerPkg::*;

	// Decoded fields, before the stage register
	branchTypeT typeNext;
	funcCodeT funcNext;
	regIdxT rsNext;
	labelT labelNext;

	//////////////////////////////////////////////////
	// Field split
	//////////////////////////////////////////////////

	// Type field must be one-hot
	always_comb begin
		case (instr[31:29])
			3'b001: typeNext = brReg;
			3'b010: typeNext = brLabel;
			3'b100: typeNext = brTest;
			// Zero or multi-hot, treated as a sequential step
			default: typeNext = brNone;
		endcase
	end

	assign funcNext = instr[28:26];

	// Register index shares bits with the upper label
	assign rsNext = instr[23:19];

	// Test branches only carry a 19-bit label
	always_comb begin
		if (typeNext == brTest) begin
			labelNext = {5'd0, instr[18:0]};
		end else begin
			labelNext = instr[23:0];
		end
	end

	//////////////////////////////////////////////////
	// Stage register
	//////////////////////////////////////////////////

	// Strobe follows instrValid by one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= instrValid;
		end
	end

	// Payload, loaded only with a strobe
	always_ff @(posedge clk) begin
		if (instrValid) begin
			dec.bType <= typeNext;
			dec.func  <= funcNext;
			dec.rs    <= rsNext;
			dec.label <= labelNext;
		end
	end

endmodule

// ==== source/seqInterfaces.sv ====
`timescale 1ns/100ps

//////////////////////////////////////////////////
// Decode to operand fetch
//////////////////////////////////////////////////

interface decodeIf;
	import pcSequencerPkg::*;

	// Single-cycle strobe, fields valid only with it
	logic valid;
	branchTypeT bType;
	funcCodeT func;
	// Operand register for br and test branches
	regIdxT rs;
	// Already zero-extended for test branches
	labelT label;

	modport source (output valid, bType, func, rs, label);
	modport sink (input valid, bType, func, rs, label);
endinterface

//////////////////////////////////////////////////
// Operand fetch to resolve
//////////////////////////////////////////////////

interface fetchIf;
	import pcSequencerPkg::*;

	logic valid;
	branchTypeT bType;
	funcCodeT func;
	labelT label;
	// Register rs as read in the fetch cycle
	wordT regData;
	// Carry flag as read in the fetch cycle
	logic carry;

	modport source (output valid, bType, func, label, regData, carry);
	modport sink (input valid, bType, func, label, regData, carry);
endinterface

// ==== source/pcSequencerPkg.sv ====
package pcSequencerPkg;

	//////////////////////////////////////////////////
	// Widths from the instruction format
	//////////////////////////////////////////////////

	// Instruction address, counts whole words
	typedef logic [31:0] addrT;

	// Register data word
	typedef logic [31:0] wordT;

	// Register index, bits 23 to 19
	typedef logic [4:0] regIdxT;

	// Branch label, 24 bits wide after decode
	typedef logic [23:0] labelT;

	// Branch type field, bits 31 to 29, one-hot
	// Any other pattern decodes to brNone
	typedef enum logic [2:0] {
		brNone  = 3'b000,
		brReg   = 3'b001,
		brLabel = 3'b010,
		brTest  = 3'b100
	} branchTypeT;

	// Function code, bits 28 to 26
	// Same codes mean different things per branch type
	typedef logic [2:0] funcCodeT;

	// Label branches
	localparam funcCodeT fnB    = 3'b000;
	localparam funcCodeT fnBl   = 3'b001;
	localparam funcCodeT fnBcy  = 3'b010;
	localparam funcCodeT fnBcny = 3'b011;

	// Register-test branches
	localparam funcCodeT fnBltz = 3'b000;
	localparam funcCodeT fnBz   = 3'b001;
	localparam funcCodeT fnBnz  = 3'b010;

endpackage

// ==== include/pcSequencer_config.svh ====
`ifndef PCSEQUENCER_CONFIG_SVH
`define PCSEQUENCER_CONFIG_SVH

//////////////////////////////////////////////////
// Register file geometry
//////////////////////////////////////////////////

// General registers, one per 5-bit index
`define SEQ_REG_COUNT 32

// Return address target for branch-and-link
`define SEQ_LINK_REG 31

//////////////////////////////////////////////////
// Program counter and run length
//////////////////////////////////////////////////

// Counter value after reset
`define SEQ_RESET_PC 32'd0

// Stimulus cycles in simulation
`define SEQ_TEST_COUNT 3000

`endif
